/* rtl/skinny_defs.svh */
`ifndef SKINNY_DEFS_SVH
`define SKINNY_DEFS_SVH

// Byte addresses, each block base spans four words
`define SKINNY_STATE_BASE    8'h00
`define SKINNY_TK1_BASE      8'h10
`define SKINNY_TK2_BASE      8'h20
`define SKINNY_TK3_BASE      8'h30

`define SKINNY_CTRL_ADDR     8'h40  // write-only
`define SKINNY_STAT_ADDR     8'h44  // {rc, round count}

// Control word bits
`define SKINNY_CTRL_ROUND    0
`define SKINNY_CTRL_RESTART  1

// Round sequencing
`define SKINNY_ROUNDS_384    56
`define SKINNY_RCOUNT_MAX    8'hFF
`define SKINNY_RC_INIT       6'h00

`endif

/* rtl/skinny_cipher_pkg.sv */
`default_nettype none

package skinny_cipher_pkg;

   // Cell 0 sits in bits 127:120, rows are 32-bit groups top to bottom
   typedef logic [127:0] block_t;

   typedef logic [7:0] cell_t;

   // 6-bit round constant LFSR value
   typedef logic [5:0] rcon_t;

   typedef logic [7:0] rcount_t;  // Rounds done, saturating

endpackage

`default_nettype wire

/* rtl/skinny_bus_pkg.sv */
`default_nettype none

package skinny_bus_pkg;

   typedef logic [7:0] wb_addr_t;  // Byte address

   typedef logic [31:0] wb_data_t;

   typedef logic [3:0] wb_sel_t;

endpackage

`default_nettype wire

/* rtl/skinny_sbox8.sv */
`timescale 1ns/1ps
`default_nettype none

module skinny_sbox8 (
   input  wire skinny_cipher_pkg::cell_t si,
   output skinny_cipher_pkg::cell_t      so
);

   logic [7:0] a;

   // (x nor y) xor z
   function automatic logic nx(input logic x, input logic y, input logic z);
      return ~(x | y) ^ z;
   endfunction

   // Each step feeds the later ones
   assign a[0] = nx(si[7], si[6], si[4]);
   assign a[1] = nx(si[3], si[2], si[0]);
   assign a[2] = nx(si[2], si[1], si[6]);
   assign a[3] = nx(a[0],  a[1],  si[5]);
   assign a[4] = nx(a[1],  si[3], si[1]);
   assign a[5] = nx(a[2],  a[3],  si[7]);
   assign a[6] = nx(a[3],  a[0],  si[3]);
   assign a[7] = nx(a[4],  a[5],  si[2]);

   // Output bit order
   assign so = {a[3], a[0], a[1], a[6], a[4], a[2], a[5], a[7]};

endmodule

`default_nettype wire

/* rtl/skinny_round_mix.sv */
`timescale 1ns/1ps
`default_nettype none

module skinny_round_mix (
   input  wire skinny_cipher_pkg::block_t sb,
   input  wire skinny_cipher_pkg::block_t tk1_q,
   input  wire skinny_cipher_pkg::block_t tk2_q,
   input  wire skinny_cipher_pkg::block_t tk3_q,
   input  wire skinny_cipher_pkg::rcon_t  rc,
   output skinny_cipher_pkg::block_t      state_next,
   output skinny_cipher_pkg::block_t      tk1_next,
   output skinny_cipher_pkg::block_t      tk2_next,
   output skinny_cipher_pkg::block_t      tk3_next
);

   // Tweakey cell permutation, output cell i takes input cell PT[i]
   localparam int PT [16] = '{9, 15, 8, 13, 10, 14, 12, 11, 0, 1, 2, 3, 4, 5, 6, 7};

   skinny_cipher_pkg::block_t rtk;
   skinny_cipher_pkg::block_t atk;
   skinny_cipher_pkg::block_t tk2_p;
   skinny_cipher_pkg::block_t tk3_p;
   logic [31:0]               shr [4];
   logic [31:0]               mxc [4];

   function automatic skinny_cipher_pkg::block_t cell_perm(
      input skinny_cipher_pkg::block_t blk
   );
      skinny_cipher_pkg::block_t res;
      for (int i = 0; i < 16; i++) begin
         res[127 - 8*i -: 8] = blk[127 - 8*PT[i] -: 8];
      end
      return res;
   endfunction

   function automatic skinny_cipher_pkg::cell_t lfsr2(input skinny_cipher_pkg::cell_t c);
      return {c[6:0], c[7] ^ c[5]};
   endfunction

   function automatic skinny_cipher_pkg::cell_t lfsr3(input skinny_cipher_pkg::cell_t c);
      return {c[0] ^ c[6], c[7:1]};
   endfunction

   // Round tweakey, top two rows only, plus constants in cells 0, 4 and 8
   assign rtk = {tk1_q[127:64] ^ tk2_q[127:64] ^ tk3_q[127:64], 64'h0}
              ^ {4'h0, rc[3:0], 24'h0, 6'h0, rc[5:4], 24'h0, 8'h02, 56'h0};

   assign atk = sb ^ rtk;

   // ShiftRows, row r rotated right by r cells
   assign shr[0] = atk[127:96];
   assign shr[1] = {atk[71:64], atk[95:72]};
   assign shr[2] = {atk[47:32], atk[63:48]};
   assign shr[3] = {atk[23:0], atk[31:24]};

   // MixColumns
   assign mxc[1] = shr[0];
   assign mxc[2] = shr[1] ^ shr[2];
   assign mxc[3] = shr[0] ^ shr[2];
   assign mxc[0] = shr[3] ^ mxc[3];

   assign state_next = {mxc[0], mxc[1], mxc[2], mxc[3]};

   // Tweakey schedule
   assign tk1_next = cell_perm(tk1_q);  // Permute only
   assign tk2_p    = cell_perm(tk2_q);
   assign tk3_p    = cell_perm(tk3_q);

   always_comb begin
      tk2_next = tk2_p;
      tk3_next = tk3_p;
      // LFSRs act on the top two rows
      for (int c = 0; c < 8; c++) begin
         tk2_next[127 - 8*c -: 8] = lfsr2(tk2_p[127 - 8*c -: 8]);
         tk3_next[127 - 8*c -: 8] = lfsr3(tk3_p[127 - 8*c -: 8]);
      end
   end

endmodule

`default_nettype wire

/* rtl/skinny_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "skinny_defs.svh"

module skinny_wb_regs (
   input  wire                               clk,
   input  wire                               arst_n,
   input  wire                               wb_cyc,
   input  wire                               wb_stb,
   input  wire                               wb_we,
   input  wire skinny_bus_pkg::wb_addr_t     wb_adr,
   input  wire skinny_bus_pkg::wb_data_t     wb_dat_w,
   input  wire skinny_bus_pkg::wb_sel_t      wb_sel,
   output skinny_bus_pkg::wb_data_t          wb_dat_r,
   output logic                              wb_ack,
   output skinny_cipher_pkg::block_t         state_q,
   output skinny_cipher_pkg::block_t         tk1_q,
   output skinny_cipher_pkg::block_t         tk2_q,
   output skinny_cipher_pkg::block_t         tk3_q,
   output skinny_cipher_pkg::rcon_t          rc_next,
   input  wire skinny_cipher_pkg::block_t    state_next,
   input  wire skinny_cipher_pkg::block_t    tk1_next,
   input  wire skinny_cipher_pkg::block_t    tk2_next,
   input  wire skinny_cipher_pkg::block_t    tk3_next
);

   skinny_cipher_pkg::rcon_t   rc_q;
   skinny_cipher_pkg::rcount_t rcount_q;
   skinny_bus_pkg::wb_addr_t   word_adr;
   skinny_bus_pkg::wb_addr_t   region;
   skinny_bus_pkg::wb_data_t   rd_data;
   logic                       access;

   // Byte-selected write of one word, word 0 is the top of the block
   function automatic skinny_cipher_pkg::block_t put_word(
      input skinny_cipher_pkg::block_t blk,
      input logic [1:0]                idx,
      input skinny_bus_pkg::wb_data_t  dat,
      input skinny_bus_pkg::wb_sel_t   sel
   );
      skinny_cipher_pkg::block_t res;
      int                        lsb;
      res = blk;
      lsb = 96 - 32 * int'(idx);
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            res[lsb + 8*b +: 8] = dat[8*b +: 8];
         end
      end
      return res;
   endfunction

   function automatic skinny_bus_pkg::wb_data_t get_word(
      input skinny_cipher_pkg::block_t blk,
      input logic [1:0]                idx
   );
      int lsb;
      lsb = 96 - 32 * int'(idx);
      return blk[lsb +: 32];
   endfunction

   // New access only while no ack is pending
   assign access   = wb_cyc & wb_stb & ~wb_ack;
   assign word_adr = {wb_adr[7:2], 2'b00};
   assign region   = {word_adr[7:4], 4'h0};

   // Shift up, new bit 0 is xnor of bits 5 and 4
   assign rc_next = {rc_q[4:0], ~(rc_q[5] ^ rc_q[4])};

   always_comb begin
      case (region)
         `SKINNY_STATE_BASE: rd_data = get_word(state_q, word_adr[3:2]);
         `SKINNY_TK1_BASE:   rd_data = get_word(tk1_q, word_adr[3:2]);
         `SKINNY_TK2_BASE:   rd_data = get_word(tk2_q, word_adr[3:2]);
         `SKINNY_TK3_BASE:   rd_data = get_word(tk3_q, word_adr[3:2]);
         default: begin
            if (word_adr == `SKINNY_STAT_ADDR) begin
               rd_data = {18'h0, rc_q, rcount_q};
            end else begin
               rd_data = '0;  // Ctrl and unmapped
            end
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_ack   <= 1'b0;
         wb_dat_r <= '0;
         state_q  <= '0;
         tk1_q    <= '0;
         tk2_q    <= '0;
         tk3_q    <= '0;
         rc_q     <= `SKINNY_RC_INIT;
         rcount_q <= '0;
      end else begin
         wb_ack <= access;

         if (access && !wb_we) begin
            wb_dat_r <= rd_data;
         end

         if (access && wb_we) begin
            case (region)
               `SKINNY_STATE_BASE: state_q <= put_word(state_q, word_adr[3:2], wb_dat_w, wb_sel);
               `SKINNY_TK1_BASE:   tk1_q <= put_word(tk1_q, word_adr[3:2], wb_dat_w, wb_sel);
               `SKINNY_TK2_BASE:   tk2_q <= put_word(tk2_q, word_adr[3:2], wb_dat_w, wb_sel);
               `SKINNY_TK3_BASE:   tk3_q <= put_word(tk3_q, word_adr[3:2], wb_dat_w, wb_sel);
               default: begin
                  if (word_adr == `SKINNY_CTRL_ADDR) begin
                     if (wb_dat_w[`SKINNY_CTRL_RESTART]) begin
                        rc_q     <= `SKINNY_RC_INIT;
                        rcount_q <= '0;
                     end else if (wb_dat_w[`SKINNY_CTRL_ROUND]) begin
                        // Commit one full round
                        state_q <= state_next;
                        tk1_q   <= tk1_next;
                        tk2_q   <= tk2_next;
                        tk3_q   <= tk3_next;
                        rc_q    <= rc_next;
                        if (rcount_q != `SKINNY_RCOUNT_MAX) begin
                           rcount_q <= rcount_q + 1'b1;
                        end
                     end
                  end
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/skinny_wb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module skinny_wb_core (
   input  wire                           clk,
   input  wire                           arst_n,
   input  wire                           wb_cyc,
   input  wire                           wb_stb,
   input  wire                           wb_we,
   input  wire skinny_bus_pkg::wb_addr_t wb_adr,
   input  wire skinny_bus_pkg::wb_data_t wb_dat_w,
   input  wire skinny_bus_pkg::wb_sel_t  wb_sel,
   output skinny_bus_pkg::wb_data_t      wb_dat_r,
   output logic                          wb_ack
);

   wire skinny_cipher_pkg::block_t state_q;
   wire skinny_cipher_pkg::block_t tk1_q;
   wire skinny_cipher_pkg::block_t tk2_q;
   wire skinny_cipher_pkg::block_t tk3_q;
   wire skinny_cipher_pkg::block_t sb;
   wire skinny_cipher_pkg::block_t state_next;
   wire skinny_cipher_pkg::block_t tk1_next;
   wire skinny_cipher_pkg::block_t tk2_next;
   wire skinny_cipher_pkg::block_t tk3_next;
   wire skinny_cipher_pkg::rcon_t  rc_next;

   skinny_wb_regs i_regs (
      .clk        (clk),
      .arst_n     (arst_n),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_sel     (wb_sel),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .state_q    (state_q),
      .tk1_q      (tk1_q),
      .tk2_q      (tk2_q),
      .tk3_q      (tk3_q),
      .rc_next    (rc_next),
      .state_next (state_next),
      .tk1_next   (tk1_next),
      .tk2_next   (tk2_next),
      .tk3_next   (tk3_next)
   );

   // SubCells, one S-box per cell
   for (genvar g = 0; g < 16; g++) begin : g_sbox
      skinny_sbox8 i_sbox (
         .si (state_q[127 - 8*g -: 8]),
         .so (sb[127 - 8*g -: 8])
      );
   end

   // Round uses the advanced constant
   skinny_round_mix i_round_mix (
      .sb         (sb),
      .tk1_q      (tk1_q),
      .tk2_q      (tk2_q),
      .tk3_q      (tk3_q),
      .rc         (rc_next),
      .state_next (state_next),
      .tk1_next   (tk1_next),
      .tk2_next   (tk2_next),
      .tk3_next   (tk3_next)
   );

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int RST_CYCLES = 10
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period
   end

   // Reset edge a little after time zero, release on a falling edge
   initial begin
      arst_n = 1'b1;
      #1 arst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* testbench/skinny_wb_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module skinny_wb_chk (
   input wire clk,
   input wire arst_n,
   input wire wb_cyc,
   input wire wb_stb,
   input wire wb_ack
);

   int unsigned fail_cnt = 0;  // Read by the testbench

   // Classic single access, ack lasts one cycle
   ack_single: assert property (@(posedge clk) disable iff (!arst_n)
      wb_ack |=> !wb_ack)
   else begin
      $error("wb_ack high for two cycles in a row");
      fail_cnt++;
   end

   ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(wb_ack) |-> $past(wb_cyc & wb_stb))
   else begin
      $error("wb_ack rose without a request in the cycle before");
      fail_cnt++;
   end

   // No ack while in reset
   ack_in_reset: assert property (@(posedge clk)
      !arst_n |-> !wb_ack)
   else begin
      $error("wb_ack high during reset");
      fail_cnt++;
   end

endmodule

`default_nettype wire

/* testbench/skinny_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "skinny_defs.svh"

module skinny_tb;

   localparam int ACCESSES       = 330;  // Upper bound on bus accesses over all tests
   localparam int TIMEOUT_CYCLES = 3 * ACCESSES * 3 + 30;
   localparam int PERM [16] = '{9, 15, 8, 13, 10, 14, 12, 11, 0, 1, 2, 3, 4, 5, 6, 7};

   wire                      clk;
   wire                      arst_n;
   logic                     wb_cyc;
   logic                     wb_stb;
   logic                     wb_we;
   skinny_bus_pkg::wb_addr_t wb_adr;
   skinny_bus_pkg::wb_data_t wb_dat_w;
   skinny_bus_pkg::wb_sel_t  wb_sel;
   skinny_bus_pkg::wb_data_t wb_dat_r;
   wire                      wb_ack;

   skinny_cipher_pkg::block_t    m_state;
   skinny_cipher_pkg::block_t    m_tk1;
   skinny_cipher_pkg::block_t    m_tk2;
   skinny_cipher_pkg::block_t    m_tk3;
   skinny_cipher_pkg::rcon_t     m_rc;
   skinny_cipher_pkg::rcount_t   m_cnt;
   int unsigned                  err_cnt = 0;
   int unsigned                  err_mark;
   int unsigned                  test_no = 0;
   int unsigned                  tests_passed = 0;
   int unsigned                  tests_failed = 0;
   int unsigned                  cycles = 0;

   tb_clk_gen #(.RST_CYCLES(10)) i_clk_gen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   skinny_wb_core i_skinny_wb_core (
      .clk      (clk),
      .arst_n   (arst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_sel   (wb_sel),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   bind skinny_wb_core skinny_wb_chk i_wb_chk (
      .clk    (clk),
      .arst_n (arst_n),
      .wb_cyc (wb_cyc),
      .wb_stb (wb_stb),
      .wb_ack (wb_ack)
   );

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, a bus access never finished", cycles);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   function automatic skinny_cipher_pkg::cell_t cell_of(
      input skinny_cipher_pkg::block_t blk,
      input int                        i
   );
      return blk[127 - 8*i -: 8];
   endfunction

   // Four nor-xor rounds with bit permutations in between and a swap of bits 1 and 2 at the end
   function automatic skinny_cipher_pkg::cell_t sbox_ref(input skinny_cipher_pkg::cell_t x);
      skinny_cipher_pkg::cell_t y;
      y = x;
      for (int r = 0; r < 4; r++) begin
         y[4] = y[4] ^ ~(y[7] | y[6]);
         y[0] = y[0] ^ ~(y[3] | y[2]);
         if (r < 3) begin
            y = {y[2], y[1], y[7], y[6], y[4], y[0], y[3], y[5]};
         end else begin
            y = {y[7], y[6], y[5], y[4], y[3], y[1], y[2], y[0]};
         end
      end
      return y;
   endfunction

   function automatic skinny_cipher_pkg::block_t round_ref(
      input skinny_cipher_pkg::block_t s,
      input skinny_cipher_pkg::block_t k1,
      input skinny_cipher_pkg::block_t k2,
      input skinny_cipher_pkg::block_t k3,
      input skinny_cipher_pkg::rcon_t  rc
   );
      skinny_cipher_pkg::cell_t  c [16];
      skinny_cipher_pkg::cell_t  t [16];
      skinny_cipher_pkg::block_t res;
      for (int i = 0; i < 16; i++) begin
         c[i] = sbox_ref(cell_of(s, i));
      end
      for (int i = 0; i < 8; i++) begin
         c[i] = c[i] ^ cell_of(k1, i) ^ cell_of(k2, i) ^ cell_of(k3, i);
      end
      c[0] = c[0] ^ {4'h0, rc[3:0]};
      c[4] = c[4] ^ {6'h0, rc[5:4]};
      c[8] = c[8] ^ 8'h02;
      for (int r = 0; r < 4; r++) begin
         for (int j = 0; j < 4; j++) begin
            t[4*r + j] = c[4*r + (j + 4 - r) % 4];  // Row r rotated right by r
         end
      end
      for (int j = 0; j < 4; j++) begin
         res[127 - 8*j -: 8]        = t[j] ^ t[8 + j] ^ t[12 + j];
         res[127 - 8*(4 + j) -: 8]  = t[j];
         res[127 - 8*(8 + j) -: 8]  = t[4 + j] ^ t[8 + j];
         res[127 - 8*(12 + j) -: 8] = t[j] ^ t[8 + j];
      end
      return res;
   endfunction

   // Kind 2 or 3 picks the LFSR of the top two rows and kind 1 picks none
   function automatic skinny_cipher_pkg::block_t tk_sched(
      input skinny_cipher_pkg::block_t blk,
      input int                        kind
   );
      skinny_cipher_pkg::block_t res;
      skinny_cipher_pkg::cell_t  x;
      for (int i = 0; i < 16; i++) begin
         x = cell_of(blk, PERM[i]);
         if (i < 8 && kind == 2) begin
            x = {x[6:0], x[7] ^ x[5]};
         end else if (i < 8 && kind == 3) begin
            x = {x[0] ^ x[6], x[7:1]};
         end
         res[127 - 8*i -: 8] = x;
      end
      return res;
   endfunction

   task automatic model_round();
      m_rc    = {m_rc[4:0], m_rc[5] ^ m_rc[4] ^ 1'b1};
      m_state = round_ref(m_state, m_tk1, m_tk2, m_tk3, m_rc);
      m_tk1   = tk_sched(m_tk1, 1);
      m_tk2   = tk_sched(m_tk2, 2);
      m_tk3   = tk_sched(m_tk3, 3);
      if (m_cnt != 8'hFF) begin
         m_cnt = m_cnt + 8'd1;
      end
   endtask

   task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] got);
      assert (got === exp) else begin
         $display("ERROR at %0d ns: %s expected %h got %h", $time, name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic bus_write(
      input skinny_bus_pkg::wb_addr_t adr,
      input skinny_bus_pkg::wb_data_t dat,
      input skinny_bus_pkg::wb_sel_t  sel
   );
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = adr;
      wb_dat_w = dat;
      wb_sel   = sel;
      @(negedge clk);
      while (wb_ack !== 1'b1) @(negedge clk);
      @(negedge clk);  // Request still up across the ack edge
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic bus_read(
      input  skinny_bus_pkg::wb_addr_t adr,
      output skinny_bus_pkg::wb_data_t dat
   );
      @(negedge clk);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = adr;
      wb_sel = 4'hF;
      @(negedge clk);
      while (wb_ack !== 1'b1) @(negedge clk);
      dat = wb_dat_r;
      @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   task automatic write_block(
      input skinny_bus_pkg::wb_addr_t  base,
      input skinny_cipher_pkg::block_t blk
   );
      for (int w = 0; w < 4; w++) begin
         bus_write(base + 8'(4*w), blk[127 - 32*w -: 32], 4'hF);
      end
   endtask

   task automatic check_block(input string name, input skinny_bus_pkg::wb_addr_t base,
                              input skinny_cipher_pkg::block_t exp);
      skinny_cipher_pkg::block_t got;
      skinny_bus_pkg::wb_data_t  d;
      for (int w = 0; w < 4; w++) begin
         bus_read(base + 8'(4*w), d);
         got[127 - 32*w -: 32] = d;
      end
      check_val(name, exp, got);
   endtask

   task automatic check_status();
      skinny_bus_pkg::wb_data_t d;
      bus_read(`SKINNY_STAT_ADDR, d);
      check_val("status", {18'h0, m_rc, m_cnt}, d);
   endtask

   task automatic load_all();
      write_block(`SKINNY_STATE_BASE, m_state);
      write_block(`SKINNY_TK1_BASE, m_tk1);
      write_block(`SKINNY_TK2_BASE, m_tk2);
      write_block(`SKINNY_TK3_BASE, m_tk3);
   endtask

   task automatic check_all();
      check_block("state", `SKINNY_STATE_BASE, m_state);
      check_block("tk1", `SKINNY_TK1_BASE, m_tk1);
      check_block("tk2", `SKINNY_TK2_BASE, m_tk2);
      check_block("tk3", `SKINNY_TK3_BASE, m_tk3);
      check_status();
   endtask

   task automatic do_round();
      bus_write(`SKINNY_CTRL_ADDR, 32'(1) << `SKINNY_CTRL_ROUND, 4'hF);
      model_round();
   endtask

   task automatic do_restart();
      bus_write(`SKINNY_CTRL_ADDR, 32'(1) << `SKINNY_CTRL_RESTART, 4'hF);
      m_rc  = `SKINNY_RC_INIT;
      m_cnt = '0;
   endtask

   function automatic skinny_cipher_pkg::block_t rand_block();
      return {$urandom(), $urandom(), $urandom(), $urandom()};
   endfunction

   task automatic start_test();
      test_no++;
      err_mark = err_cnt;
   endtask

   task automatic end_test(input string name);
      if (err_cnt == err_mark) begin
         tests_passed++;
         $display("Test %0d %s: passed", test_no, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: failed with %0d errors", test_no, name, err_cnt - err_mark);
      end
   endtask

   initial begin
      skinny_bus_pkg::wb_data_t d;
      int unsigned              chk_fails;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      wb_sel   = '0;
      m_state  = '0;
      m_tk1    = '0;
      m_tk2    = '0;
      m_tk3    = '0;
      m_rc     = '0;
      m_cnt    = '0;
      void'($urandom(32'h354504d9));
      wait (arst_n === 1'b0);
      wait (arst_n === 1'b1);

      start_test();
      check_all();
      end_test("reset values");

      start_test();
      m_state = rand_block();
      m_tk1   = rand_block();
      m_tk2   = rand_block();
      m_tk3   = rand_block();
      load_all();
      d = $urandom();
      bus_write(`SKINNY_STATE_BASE + 8'h04, d, 4'b0101);  // Bytes 0 and 2 of word 1
      m_state[71:64] = d[7:0];
      m_state[87:80] = d[23:16];
      check_all();
      end_test("write and read back");

      start_test();
      m_state = rand_block();
      m_tk1   = rand_block();
      m_tk2   = rand_block();
      m_tk3   = rand_block();
      load_all();
      do_restart();
      do_round();
      check_all();
      bus_read(`SKINNY_STAT_ADDR, d);
      check_val("status after one round", {18'h0, 6'h01, 8'h01}, d);
      end_test("single round");

      start_test();
      for (int r = 0; r < 5; r++) begin
         do_round();
         check_all();
      end
      end_test("five rounds");

      start_test();
      m_state = 128'ha3994b66ad85a3459f44e92b08f550cb;
      m_tk1   = 128'hdf889548cfc7ea52d296339301797449;
      m_tk2   = 128'hab588a34a47f1ab2dfe9c8293fbea9a5;
      m_tk3   = 128'hab1afac2611012cd8cef952618c3ebe8;
      load_all();
      do_restart();
      repeat (`SKINNY_ROUNDS_384) do_round();
      check_block("state", `SKINNY_STATE_BASE, 128'h94ecf589e2017c601b38c6346a10dcfa);
      check_status();
      end_test("known answer");

      start_test();
      bus_read(8'h48, d);
      check_val("unmapped 0x48", 32'h0, d);
      bus_read(8'h80, d);
      check_val("unmapped 0x80", 32'h0, d);
      bus_read(8'hFC, d);
      check_val("unmapped 0xfc", 32'h0, d);
      bus_write(8'h48, 32'hFFFFFFFF, 4'hF);
      bus_write(8'hC0, 32'hFFFFFFFF, 4'hF);
      check_all();
      end_test("unmapped addresses");

      chk_fails = i_skinny_wb_core.i_wb_chk.fail_cnt;
      $display("Tests: %0d passed, %0d failed, %0d check errors, %0d protocol errors",
               tests_passed, tests_failed, err_cnt, chk_fails);
      if (err_cnt == 0 && tests_failed == 0 && chk_fails == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/skinny_cipher_pkg.sv
rtl/skinny_bus_pkg.sv
rtl/skinny_sbox8.sv
rtl/skinny_round_mix.sv
rtl/skinny_wb_regs.sv
rtl/skinny_wb_core.sv
testbench/tb_clk_gen.sv
testbench/skinny_wb_chk.sv
testbench/skinny_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the SKINNY Wishbone testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f files.f --top-module skinny_tb -o skinny_sim

./obj_dir/skinny_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
